//--- procPkg.sv
/* Types shared by the 16-bit single-cycle core
   Opcode values outside opcodeT are illegal and trap in control
   Both memories hold memDepth words, upper address bits are dropped */
`default_nettype none

package procPkg;

   parameter int memDepth = 256;             // Words in imem and dmem

   typedef enum logic [4:0] {
      HALT  = 5'd0,
      NOP   = 5'd1,
      RTYPE = 5'd2,                          // ALU op in func field
      ADDI  = 5'd3,
      ANDI  = 5'd4,                          // Only zero-extended imm
      LD    = 5'd5,
      ST    = 5'd6,
      BEQZ  = 5'd7,
      BNEZ  = 5'd8,
      J     = 5'd9
   } opcodeT;

   typedef enum logic [1:0] {ADD, SUB, AND, XOR} aluOpT;

   typedef enum logic [1:0] {BR_NONE, BR_EQZ, BR_NEZ, BR_JUMP} branchT;

   // Three decodings of one instruction word
   typedef union packed {
      struct packed {
         opcodeT      op;
         logic [2:0]  rs;
         logic [2:0]  rt;
         logic [2:0]  rd;
         aluOpT       func;
      } r;
      struct packed {
         opcodeT      op;
         logic [2:0]  rs;
         logic [2:0]  rt;
         logic [4:0]  imm;
      } i;
      struct packed {
         opcodeT      op;
         logic [2:0]  rs;                    // Top of the J offset
         logic [7:0]  disp;
      } b;
   } instrU;

   typedef struct packed {
      logic    regWrite;
      logic    regDest;                      // 1 = rd, 0 = rt
      logic    aluSrc;                       // 1 = immediate operand
      aluOpT   aluOp;
      logic    memRead;
      logic    memWrite;
      logic    memToReg;
      branchT  branchCode;
      logic    halt;
   } ctlT;

   typedef struct packed {
      logic        valid;
      logic [7:0]  pc;
      logic        regWrite;
      logic [2:0]  wReg;
      logic [15:0] wData;
      logic        memWrite;
      logic [7:0]  mAddr;
      logic [15:0] mData;
   } retireT;

endpackage

`default_nettype wire

//--- fetch.sv
/* PC, instruction memory and halt latch
   imem is writable only while rst is high, no handshake on the load port
   PC stays on the HALT word once it is reached */
`default_nettype none

module fetch import procPkg::*; #(
   parameter int memDepth = procPkg::memDepth,
   localparam int addrW = $clog2(memDepth)
) (
   input  wire                clk,
   input  wire                rst,
   input  wire                imemWe,          // Program load strobe
   input  wire [addrW-1:0]    imemAddr,
   input  wire [15:0]         imemData,
   input  wire                pcSrc,           // Branch or jump taken
   input  wire                haltNow,         // HALT decoded this cycle
   input  wire [15:0]         disp,            // Extended displacement
   output instrU              instr,
   output logic [addrW-1:0]   pc,
   output logic               halted
);

   instrU imem [memDepth];                     // No reset, loaded by testbench
   logic [addrW-1:0] pcPlus1;
   logic [addrW-1:0] pcNext;

   always_ff @(posedge clk) begin
      if (rst && imemWe) begin
         imem[imemAddr] <= imemData;           // Load only under reset
      end
   end

   assign instr   = imem[pc];                  // Combinational fetch
   assign pcPlus1 = pc + 1'b1;
   assign pcNext  = pcSrc ? pcPlus1 + disp[addrW-1:0] : pcPlus1;  // Wraps in imem

   always_ff @(posedge clk) begin
      if (rst) begin
         pc     <= '0;
         halted <= 1'b0;
      end else begin
         if (!halted && !haltNow) begin
            pc <= pcNext;                      // Freeze on the HALT word
         end
         halted <= halted | haltNow;           // Sticky until reset
      end
   end

   // Frozen PC keeps pointing at a word that still decodes as HALT
   pcFrozen: assert property (@(posedge clk) disable iff (rst)
      halted |-> haltNow && pc == $past(pc))
      else $error("PC left the HALT word while halted");

endmodule

`default_nettype wire

//--- control.sv
/* Opcode decode into the control bundle and extended immediate
   Illegal opcodes give all-inactive controls and raise illegal
   Immediate is sign-extended except for ANDI */
`default_nettype none

module control import procPkg::*; (
   input  wire instrU   instr,
   output ctlT          ctl,
   output logic [15:0]  imm,
   output logic         illegal
);

   logic [15:0] immS5;                         // I view, signed
   logic [15:0] immZ5;                         // I view, unsigned
   logic [15:0] disp8;                         // B view branch offset
   logic [15:0] disp11;                        // J offset spans rs and disp

   assign immS5  = {{11{instr.i.imm[4]}}, instr.i.imm};
   assign immZ5  = {11'b0, instr.i.imm};
   assign disp8  = {{8{instr.b.disp[7]}}, instr.b.disp};
   assign disp11 = {{5{instr.b.rs[2]}}, instr.b.rs, instr.b.disp};

   always_comb begin
      ctl     = '0;                            // Everything inactive by default
      imm     = '0;
      illegal = 1'b0;
      case (instr.r.op)
         HALT: ctl.halt = 1'b1;
         NOP: ;                                // Just advance the PC
         RTYPE: begin
            ctl.regWrite = 1'b1;
            ctl.regDest  = 1'b1;               // Write rd
            ctl.aluOp    = instr.r.func;
         end
         ADDI: begin
            ctl.regWrite = 1'b1;
            ctl.aluSrc   = 1'b1;
            ctl.aluOp    = ADD;
            imm          = immS5;
         end
         ANDI: begin
            ctl.regWrite = 1'b1;
            ctl.aluSrc   = 1'b1;
            ctl.aluOp    = AND;
            imm          = immZ5;              // Mask must not sign-extend
         end
         LD: begin
            ctl.regWrite = 1'b1;
            ctl.aluSrc   = 1'b1;
            ctl.aluOp    = ADD;                // rs + offset
            ctl.memRead  = 1'b1;
            ctl.memToReg = 1'b1;
            imm          = immS5;
         end
         ST: begin
            ctl.aluSrc   = 1'b1;
            ctl.aluOp    = ADD;
            ctl.memWrite = 1'b1;               // Data comes from rt
            imm          = immS5;
         end
         BEQZ: begin
            ctl.branchCode = BR_EQZ;
            imm            = disp8;
         end
         BNEZ: begin
            ctl.branchCode = BR_NEZ;
            imm            = disp8;
         end
         J: begin
            ctl.branchCode = BR_JUMP;
            imm            = disp11;
         end
         default: illegal = 1'b1;
      endcase
   end

endmodule

`default_nettype wire

//--- decode.sv
/* Eight 16-bit registers, all cleared by rst
   Two combinational reads (rs, rt), one write at the next edge
   Register 0 is an ordinary register */
`default_nettype none

module decode import procPkg::*; (
   input  wire          clk,
   input  wire          rst,
   input  wire instrU   instr,
   input  wire ctlT     ctl,
   input  wire [15:0]   writeData,             // From writeback select
   output logic [15:0]  readData1,             // rs
   output logic [15:0]  readData2              // rt
);

   logic [15:0] rf [8];
   logic [2:0]  wAddr;

   assign wAddr = ctl.regDest ? instr.r.rd : instr.r.rt;   // R writes rd, I writes rt

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 8; i++) begin
            rf[i] <= '0;
         end
      end else if (ctl.regWrite) begin
         rf[wAddr] <= writeData;
      end
   end

   assign readData1 = rf[instr.r.rs];          // No bypass, write lands next edge
   assign readData2 = rf[instr.r.rt];

endmodule

`default_nettype wire

//--- execute.sv
/* ALU and branch condition, purely combinational
   Branch tests look at rs only, compare against zero */
`default_nettype none

module execute import procPkg::*; (
   input  wire [15:0]   readData1,
   input  wire [15:0]   readData2,
   input  wire [15:0]   imm,
   input  wire ctlT     ctl,
   output logic [15:0]  aluResult,
   output logic         pcSrc
);

   logic [15:0] opB;
   logic        isZero;

   assign opB    = ctl.aluSrc ? imm : readData2;   // Immediate or rt
   assign isZero = (readData1 == 16'd0);

   always_comb begin
      case (ctl.aluOp)
         ADD: aluResult = readData1 + opB;        // Also address calc
         SUB: aluResult = readData1 - opB;
         AND: aluResult = readData1 & opB;
         XOR: aluResult = readData1 ^ opB;
         default: aluResult = '0;
      endcase
   end

   always_comb begin
      case (ctl.branchCode)
         BR_EQZ:  pcSrc = isZero;
         BR_NEZ:  pcSrc = !isZero;
         BR_JUMP: pcSrc = 1'b1;
         default: pcSrc = 1'b0;                   // Fall through to PC+1
      endcase
   end

endmodule

`default_nettype wire

//--- memory.sv
/* Data memory, not reset, so contents are unknown until written
   Write at the next edge, read combinational, upper address bits ignored */
`default_nettype none

module memory import procPkg::*; #(
   parameter int memDepth = procPkg::memDepth,
   localparam int addrW = $clog2(memDepth)
) (
   input  wire          clk,
   input  wire [15:0]   addr,                  // Straight from the ALU
   input  wire [15:0]   wData,
   input  wire ctlT     ctl,
   output logic [15:0]  rData
);

   logic [15:0] dmem [memDepth];
   logic [addrW-1:0] wordAddr;

   assign wordAddr = addr[addrW-1:0];          // Drop the high bits

   always_ff @(posedge clk) begin
      if (ctl.memWrite) begin
         dmem[wordAddr] <= wData;
      end
   end

   assign rData = ctl.memRead ? dmem[wordAddr] : '0;   // Quiet unless LD

   // Decoder must never ask for both at once
   noReadWrite: assert property (@(posedge clk) !(ctl.memRead && ctl.memWrite))
      else $error("memRead and memWrite both set");

endmodule

`default_nettype wire

//--- proc.sv
/* Single-cycle 16-bit core, one instruction per clock after rst falls
   Program is loaded through imemWe/imemAddr/imemData only while rst is high
   retire is valid for every executed instruction, HALT included */
`default_nettype none

module proc import procPkg::*; #(
   parameter int memDepth = procPkg::memDepth,
   localparam int addrW = $clog2(memDepth)
) (
   input  wire                clk,
   input  wire                rst,
   input  wire                imemWe,
   input  wire [addrW-1:0]    imemAddr,
   input  wire [15:0]         imemData,
   output retireT             retire,
   output logic               halted,
   output logic               err            // Sticky illegal-opcode flag
);

   instrU            instr;                    // Fetch to control and decode
   logic [addrW-1:0] pc;
   ctlT              ctl;
   ctlT              memCtl;                   // ctl with stores held off when idle
   logic [15:0]      immExtend;
   logic             illegal;
   logic [15:0]      readData1;
   logic [15:0]      readData2;
   logic [15:0]      aluResult;
   logic             pcSrc;
   logic [15:0]      memReadData;
   logic [15:0]      regWriteData;             // Writeback to decode
   logic             run;                      // An instruction executes this cycle

   assign run = !rst && !halted;

   always_comb begin
      memCtl          = ctl;
      memCtl.memWrite = ctl.memWrite & run;    // No stores while loading
   end

   fetch #(.memDepth(memDepth)) fetch0 (
      .clk(clk), .rst(rst),
      .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
      .pcSrc(pcSrc), .haltNow(ctl.halt), .disp(immExtend),
      .instr(instr), .pc(pc), .halted(halted));

   control control0 (.instr(instr), .ctl(ctl), .imm(immExtend), .illegal(illegal));

   decode decode0 (
      .clk(clk), .rst(rst), .instr(instr), .ctl(ctl),
      .writeData(regWriteData), .readData1(readData1), .readData2(readData2));

   execute execute0 (
      .readData1(readData1), .readData2(readData2), .imm(immExtend),
      .ctl(ctl), .aluResult(aluResult), .pcSrc(pcSrc));

   memory #(.memDepth(memDepth)) memory0 (
      .clk(clk), .addr(aluResult), .wData(readData2),
      .ctl(memCtl), .rData(memReadData));

   assign regWriteData = ctl.memToReg ? memReadData : aluResult;   // Writeback select

   always_ff @(posedge clk) begin
      if (rst) begin
         err <= 1'b0;
      end else if (illegal && run) begin
         err <= 1'b1;                          // Held until next reset
      end
   end

   always_comb begin
      retire.valid    = run;
      retire.pc       = pc;
      retire.regWrite = ctl.regWrite;
      retire.wReg     = ctl.regDest ? instr.r.rd : instr.r.rt;
      retire.wData    = regWriteData;
      retire.memWrite = ctl.memWrite;
      retire.mAddr    = aluResult[7:0];        // Word address seen by dmem
      retire.mData    = readData2;
   end

   // Trapped word must leave registers, memory and PC path untouched
   illegalQuiet: assert property (@(posedge clk) disable iff (rst) illegal |-> ctl == '0)
      else $error("Illegal opcode left controls active");

endmodule

`default_nettype wire

//--- procTb.sv
/* Random-program testbench for the single-cycle core
   Each program is loaded under rst, run to HALT and checked cycle by cycle
   LD only reads words that an always-executed ST has written
   One program carries an illegal opcode to exercise err */
`default_nettype none

module procTb import procPkg::*; ();

   localparam int numProgs    = 20;
   localparam int progLen     = 60;                      // Last word is HALT
   localparam int illegalProg = 7;                       // Program with the bad opcode
   localparam int cycleLimit  = numProgs * (2 * progLen + 20);   // Load + run + margin

   logic        clk;
   logic        rst;
   logic        imemWe;
   logic [7:0]  imemAddr;
   logic [15:0] imemData;
   retireT      retire;
   logic        halted;
   logic        err;

   integer      seed;
   int          errCount;
   int          checkCount;
   int          cycles;
   logic [15:0] prog [progLen];
   bit          known [256];                             // dmem words safe to load
   logic [15:0] mReg [8];                                // Model state
   logic [15:0] mMem [256];
   logic [7:0]  mPc;
   logic        mHalted;
   logic        mErr;

   proc #(.memDepth(memDepth)) i_proc (
      .clk(clk), .rst(rst), .imemWe(imemWe), .imemAddr(imemAddr),
      .imemData(imemData), .retire(retire), .halted(halted), .err(err));

   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycleLimit) begin
         $display("Timeout: the processor did not halt within %0d cycles", cycleLimit);
         $display("Test FAILED");
         $finish;
      end
   end

   task automatic checkVal(input string name, input logic [15:0] got,
                           input logic [15:0] exp);
      checkCount++;
      if (got !== exp) begin
         errCount++;
         $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic genProgram(input bit withIllegal);
      int          r;
      int          d;
      logic [4:0]  base;
      logic [4:0]  off;
      logic [4:0]  kind;
      logic [2:0]  rtw;
      logic [2:0]  rdw;
      logic [7:0]  addr8;
      bit          covered [progLen];                    // Indices a branch may skip
      for (int k = 0; k < progLen; k++) begin
         covered[k] = 1'b0;
      end
      r = $random(seed);
      base = {1'b0, r[3:0]};
      prog[0] = {ADDI, 3'd7, 3'd7, base};                // r7 holds the LD/ST base
      for (int k = withIllegal ? 2 : 1; k < progLen - 1; k++) begin   // Slot 1 may be bad
         r = $random(seed);
         kind = r[7:0] % 10;
         rtw = r[13:11] % 7;                             // Never overwrite r7
         rdw = r[16:14] % 7;
         off = r[23:19];
         addr8 = {3'b0, base} + {{3{off[4]}}, off};
         d = r[30:24] % (progLen - 1 - k);               // Target stays at or before HALT
         case (kind)
            0: prog[k] = {NOP, 11'd0};
            1, 9: prog[k] = {RTYPE, r[10:8], r[13:11], rdw, r[18:17]};
            2: prog[k] = {ADDI, r[10:8], rtw, off};
            3: prog[k] = {ANDI, r[10:8], rtw, off};
            4, 5: begin
               if (kind == 4 && known[addr8]) begin
                  prog[k] = {LD, 3'd7, rtw, off};
               end else begin
                  prog[k] = {ST, 3'd7, r[13:11], off};
                  if (!covered[k]) begin
                     known[addr8] = 1'b1;                // Store always runs
                  end
               end
            end
            default: begin
               if (kind == 6) begin
                  prog[k] = {BEQZ, r[10:8], d[7:0]};
               end else if (kind == 7) begin
                  prog[k] = {BNEZ, r[10:8], d[7:0]};
               end else begin
                  prog[k] = {J, d[10:0]};
               end
               for (int j = 1; j <= d; j++) begin
                  covered[k + j] = 1'b1;
               end
            end
         endcase
      end
      if (withIllegal) begin
         r = $random(seed);
         prog[1] = {5'd10 + r[4:0] % 22, r[15:5]};       // Opcode 10..31
      end
      prog[progLen - 1] = {HALT, 11'd0};
   endtask

   task automatic loadProgram();
      @(posedge clk);
      rst <= 1'b1;
      for (int k = 0; k < progLen; k++) begin
         imemWe   <= 1'b1;
         imemAddr <= k[7:0];
         imemData <= prog[k];
         @(posedge clk);
      end
      imemWe <= 1'b0;
      rst    <= 1'b0;                                    // Last word lands on this edge
   endtask

   task automatic checkCycle();
      logic [15:0] w;
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] s5;
      logic [15:0] expData;
      logic [7:0]  nextPc;
      logic [7:0]  addr;
      logic [2:0]  expReg;
      logic        expWe;
      logic        expMw;
      checkVal("halted", halted, mHalted);
      checkVal("err", err, mErr);
      checkVal("retire.pc", retire.pc, mPc);
      checkVal("retire.valid", retire.valid, !mHalted);
      if (!mHalted) begin
         w = prog[mPc];
         a = mReg[w[10:8]];
         b = mReg[w[7:5]];
         s5 = {{11{w[4]}}, w[4:0]};
         addr = a[7:0] + s5[7:0];                        // Word address wraps at 256
         nextPc = mPc + 8'd1;
         expWe = 1'b0;
         expMw = 1'b0;
         expReg = w[7:5];
         expData = a + s5;
         case (w[15:11])
            HALT: begin
               mHalted = 1'b1;
               nextPc = mPc;
            end
            NOP: ;
            RTYPE: begin
               expWe = 1'b1;
               expReg = w[4:2];
               case (w[1:0])
                  2'd0: expData = a + b;
                  2'd1: expData = a - b;
                  2'd2: expData = a & b;
                  default: expData = a ^ b;
               endcase
            end
            ADDI: expWe = 1'b1;
            ANDI: begin
               expWe = 1'b1;
               expData = a & {11'd0, w[4:0]};            // Zero-extended mask
            end
            LD: begin
               expWe = 1'b1;
               expData = mMem[addr];
            end
            ST: expMw = 1'b1;
            BEQZ: nextPc = (a == 16'd0) ? nextPc + w[7:0] : nextPc;
            BNEZ: nextPc = (a != 16'd0) ? nextPc + w[7:0] : nextPc;
            J: nextPc = nextPc + w[7:0];                 // Upper offset bits fall off
            default: mErr = 1'b1;
         endcase
         checkVal("retire.regWrite", retire.regWrite, expWe);
         if (expWe) begin
            checkVal("retire.wReg", retire.wReg, expReg);
            checkVal("retire.wData", retire.wData, expData);
            mReg[expReg] = expData;
         end
         checkVal("retire.memWrite", retire.memWrite, expMw);
         if (expMw) begin
            checkVal("retire.mAddr", retire.mAddr, addr);
            checkVal("retire.mData", retire.mData, b);
            mMem[addr] = b;
         end
         mPc = nextPc;
      end
   endtask

   task automatic runProgram();
      int postHalt;
      postHalt = 0;
      mPc = 8'd0;
      mHalted = 1'b0;
      mErr = 1'b0;
      for (int k = 0; k < 8; k++) begin
         mReg[k] = 16'd0;
      end
      while (postHalt < 4) begin
         @(negedge clk);                                 // Outputs settled here
         checkCycle();
         if (mHalted) begin
            postHalt++;
         end
      end
   endtask

   initial begin
      clk = 1'b0;
      rst = 1'b1;
      imemWe = 1'b0;
      imemAddr = 8'd0;
      imemData = 16'd0;
      seed = 32'h365e_22c0;
      errCount = 0;
      checkCount = 0;
      cycles = 0;
      for (int k = 0; k < 256; k++) begin
         known[k] = 1'b0;
      end
      for (int p = 0; p < numProgs; p++) begin
         genProgram(p == illegalProg);
         loadProgram();
         runProgram();
      end
      $display("%0d checks, %0d errors", checkCount, errCount);
      if (errCount == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- proc.f
procPkg.sv
fetch.sv
control.sv
decode.sv
execute.sv
memory.sv
proc.sv
procTb.sv
